/* logic/branch_cond.sv */
`timescale 1ns/1ps

module branch_cond #(
	parameter int data_bits = 32
) (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  refresh,
	input  logic [data_bits-1:0]  rs1,
	input  logic [data_bits-1:0]  rs2,
	input  branch_pkg::br_func_e  func,
	output logic                  cond
);
	import branch_pkg::*;

	logic equal;
	logic less_signed;
	logic less_unsigned;
	logic cond_next;

	assign equal         = (rs1 == rs2);
	assign less_signed   = ($signed(rs1) < $signed(rs2));
	assign less_unsigned = (rs1 < rs2);

	always_comb begin
		case (func)
			f_beq:   cond_next = equal;
			f_bne:   cond_next = !equal;
			f_blt:   cond_next = less_signed;
			f_bge:   cond_next = !less_signed;
			f_bltu:  cond_next = less_unsigned;
			f_bgeu:  cond_next = !less_unsigned;
			default: cond_next = 1'b0;  // not a branch funct3
		endcase
	end

	// refresh drops whatever the flushed branch computed
	always_ff @(posedge clock) begin
		if (!rst_n || refresh) begin
			cond <= 1'b0;
		end else begin
			cond <= cond_next;
		end
	end

endmodule

/* logic/branch_issue_if.sv */
`timescale 1ns/1ps

// one issued branch, station to unit
interface branch_issue_if #(
	parameter int data_bits = 32,
	parameter int tag_bits  = 5
);
	import branch_pkg::*;

	logic                   valid;     // single cycle strobe
	logic [data_bits-1:0]   pc;
	logic [inst_bits-1:0]   inst;
	branch_kind_e           kind;
	logic [data_bits-1:0]   rs1_value;
	logic [data_bits-1:0]   rs2_value;
	logic [tag_bits-1:0]    dest_tag;  // result broadcast tag

	modport sender (
		output valid, pc, inst, kind,
		output rs1_value, rs2_value, dest_tag
	);

	modport receiver (
		input valid, pc, inst, kind,
		input rs1_value, rs2_value, dest_tag
	);

endinterface

/* logic/branch_pkg.sv */
package branch_pkg;

	localparam int inst_bits = 32;

	// what kind of control transfer the station is holding
	typedef enum logic [1:0] {
		br_cond = 2'd0,
		br_jal  = 2'd1,
		br_jalr = 2'd2
	} branch_kind_e;

	// conditional branch compare, RV32 funct3 values
	typedef enum logic [2:0] {
		f_beq  = 3'b000,
		f_bne  = 3'b001,
		f_blt  = 3'b100,
		f_bge  = 3'b101,
		f_bltu = 3'b110,
		f_bgeu = 3'b111
	} br_func_e;

	// I-type immediate, used by jalr
	function automatic logic signed [inst_bits-1:0] imm_i(input logic [inst_bits-1:0] inst);
		return {{20{inst[31]}}, inst[31:20]};
	endfunction

	// B-type immediate, always even
	function automatic logic signed [inst_bits-1:0] imm_b(input logic [inst_bits-1:0] inst);
		return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	endfunction

	// J-type immediate for jal
	function automatic logic signed [inst_bits-1:0] imm_j(input logic [inst_bits-1:0] inst);
		return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	endfunction

	// funct3 field viewed as a compare op
	// codes 010 and 011 are not branches and fall into the comparator default
	function automatic br_func_e funct3_of(input logic [inst_bits-1:0] inst);
		return br_func_e'(inst[14:12]);
	endfunction

endpackage

/* logic/branch_station.sv */
`timescale 1ns/1ps

module branch_station #(
	parameter int data_bits = 32,
	parameter int tag_bits  = 5
) (
	input  logic                             clock,
	input  logic                             rst_n,
	input  logic                             flush,
	input  logic                             dispatch_valid,
	input  logic [data_bits-1:0]             dispatch_pc,
	input  logic [branch_pkg::inst_bits-1:0] dispatch_inst,
	input  branch_pkg::branch_kind_e         dispatch_kind,
	input  logic                             rs1_ready,
	input  logic [tag_bits-1:0]              rs1_tag,
	input  logic [data_bits-1:0]             rs1_value,
	input  logic                             rs2_ready,
	input  logic [tag_bits-1:0]              rs2_tag,
	input  logic [data_bits-1:0]             rs2_value,
	input  logic [tag_bits-1:0]              dest_tag,
	input  logic                             cdb_valid,
	input  logic [tag_bits-1:0]              cdb_tag,
	input  logic [data_bits-1:0]             cdb_value,
	output logic                             dispatch_ready,
	branch_issue_if.sender                   issue
);
	import branch_pkg::*;

	logic                   entry_valid;
	logic                   issue_q;     // entry is on the issue bus this cycle
	logic [data_bits-1:0]   entry_pc;
	logic [inst_bits-1:0]   entry_inst;
	branch_kind_e           entry_kind;
	logic [tag_bits-1:0]    entry_dest;
	logic                   op1_rdy;
	logic                   op2_rdy;
	logic [tag_bits-1:0]    op1_tag;
	logic [tag_bits-1:0]    op2_tag;
	logic [data_bits-1:0]   op1_val;
	logic [data_bits-1:0]   op2_val;

	logic accept;
	logic hit1_new;
	logic hit2_new;
	logic hit1_held;
	logic hit2_held;

	// entry can be refilled at the same edge it leaves
	assign dispatch_ready = !entry_valid || issue_q;
	assign accept = dispatch_valid && dispatch_ready;

	// broadcast racing the dispatch
	assign hit1_new = cdb_valid && !rs1_ready && (cdb_tag == rs1_tag);
	assign hit2_new = cdb_valid && !rs2_ready && (cdb_tag == rs2_tag);

	// broadcast for an operand already waiting
	assign hit1_held = cdb_valid && entry_valid && !op1_rdy && (cdb_tag == op1_tag);
	assign hit2_held = cdb_valid && entry_valid && !op2_rdy && (cdb_tag == op2_tag);

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			entry_valid <= 1'b0;
			issue_q     <= 1'b0;
			op1_rdy     <= 1'b0;
			op2_rdy     <= 1'b0;
		end else begin
			issue_q <= entry_valid && op1_rdy && op2_rdy && !issue_q;
			if (accept) begin
				entry_valid <= 1'b1;
				op1_rdy     <= rs1_ready || hit1_new;
				op2_rdy     <= rs2_ready || hit2_new;
			end else begin
				if (issue_q) entry_valid <= 1'b0;  // freed after its issue cycle
				if (hit1_held) op1_rdy <= 1'b1;
				if (hit2_held) op2_rdy <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			entry_pc   <= dispatch_pc;
			entry_inst <= dispatch_inst;
			entry_kind <= dispatch_kind;
			entry_dest <= dest_tag;
			op1_tag    <= rs1_tag;
			op2_tag    <= rs2_tag;
			op1_val    <= hit1_new ? cdb_value : rs1_value;
			op2_val    <= hit2_new ? cdb_value : rs2_value;
		end else begin
			if (hit1_held) op1_val <= cdb_value;
			if (hit2_held) op2_val <= cdb_value;
		end
	end

	assign issue.valid     = issue_q;
	assign issue.pc        = entry_pc;
	assign issue.inst      = entry_inst;
	assign issue.kind      = entry_kind;
	assign issue.rs1_value = op1_val;
	assign issue.rs2_value = op2_val;
	assign issue.dest_tag  = entry_dest;

endmodule

/* logic/branch_top.sv */
`timescale 1ns/1ps

module branch_top #(
	parameter int data_bits = 32,
	parameter int tag_bits  = 5
) (
	input  logic                             clock,
	input  logic                             rst_n,
	input  logic                             flush,
	input  logic                             dispatch_valid,
	input  logic [data_bits-1:0]             dispatch_pc,
	input  logic [branch_pkg::inst_bits-1:0] dispatch_inst,
	input  branch_pkg::branch_kind_e         dispatch_kind,
	input  logic                             rs1_ready,
	input  logic [tag_bits-1:0]              rs1_tag,
	input  logic [data_bits-1:0]             rs1_value,
	input  logic                             rs2_ready,
	input  logic [tag_bits-1:0]              rs2_tag,
	input  logic [data_bits-1:0]             rs2_value,
	input  logic [tag_bits-1:0]              dest_tag,
	input  logic                             cdb_valid,
	input  logic [tag_bits-1:0]              cdb_tag,
	input  logic [data_bits-1:0]             cdb_value,
	output logic                             dispatch_ready,
	output logic                             result_valid,
	output logic [tag_bits-1:0]              result_tag,
	output logic                             take_branch,
	output logic [data_bits-1:0]             target,
	output logic [data_bits-1:0]             link_value
);

	branch_issue_if #(
		.data_bits (data_bits),
		.tag_bits  (tag_bits)
	) issue_bus ();

	branch_station #(
		.data_bits (data_bits),
		.tag_bits  (tag_bits)
	) station0 (
		.clock, .rst_n, .flush,
		.dispatch_valid, .dispatch_pc, .dispatch_inst, .dispatch_kind,
		.rs1_ready, .rs1_tag, .rs1_value,
		.rs2_ready, .rs2_tag, .rs2_value,
		.dest_tag,
		.cdb_valid, .cdb_tag, .cdb_value,
		.dispatch_ready,
		.issue (issue_bus.sender)
	);

	branch_unit #(
		.data_bits (data_bits),
		.tag_bits  (tag_bits)
	) unit0 (
		.clock, .rst_n, .flush,
		.issue (issue_bus.receiver),
		.result_valid, .result_tag, .take_branch, .target, .link_value
	);

endmodule

/* logic/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit #(
	parameter int data_bits = 32,
	parameter int tag_bits  = 5
) (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  flush,
	branch_issue_if.receiver      issue,
	output logic                  result_valid,
	output logic [tag_bits-1:0]   result_tag,
	output logic                  take_branch,
	output logic [data_bits-1:0]  target,
	output logic [data_bits-1:0]  link_value
);
	import branch_pkg::*;

	// stage 1, issued branch as latched
	logic                   s1_valid;
	logic [data_bits-1:0]   s1_pc;
	logic [inst_bits-1:0]   s1_inst;
	branch_kind_e           s1_kind;
	logic [data_bits-1:0]   s1_rs1;
	logic [data_bits-1:0]   s1_rs2;
	logic [tag_bits-1:0]    s1_tag;

	// stage 1 combinational
	br_func_e               s1_func;
	logic [data_bits-1:0]   imm_i_ext;
	logic [data_bits-1:0]   imm_b_ext;
	logic [data_bits-1:0]   imm_j_ext;
	logic [data_bits-1:0]   opa;
	logic [data_bits-1:0]   opb;
	logic [data_bits-1:0]   sum;
	logic [data_bits-1:0]   target_next;

	// stage 2
	logic                   s2_valid;
	branch_kind_e           s2_kind;
	logic [data_bits-1:0]   s2_target;
	logic [data_bits-1:0]   s2_link;
	logic [tag_bits-1:0]    s2_tag;
	logic                   cond;

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= issue.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (issue.valid) begin
			s1_pc   <= issue.pc;
			s1_inst <= issue.inst;
			s1_kind <= issue.kind;
			s1_rs1  <= issue.rs1_value;
			s1_rs2  <= issue.rs2_value;
			s1_tag  <= issue.dest_tag;
		end
	end

	assign s1_func   = funct3_of(s1_inst);
	assign imm_i_ext = data_bits'(imm_i(s1_inst));  // sign extended to the datapath
	assign imm_b_ext = data_bits'(imm_b(s1_inst));
	assign imm_j_ext = data_bits'(imm_j(s1_inst));

	// jalr is register relative, everything else pc relative
	assign opa = (s1_kind == br_jalr) ? s1_rs1 : s1_pc;

	always_comb begin
		case (s1_kind)
			br_jal:  opb = imm_j_ext;
			br_jalr: opb = imm_i_ext;
			default: opb = imm_b_ext;
		endcase
	end

	assign sum = opa + opb;
	assign target_next = (s1_kind == br_jalr) ? {sum[data_bits-1:1], 1'b0} : sum;

	branch_cond #(
		.data_bits (data_bits)
	) cond0 (
		.clock   (clock),
		.rst_n   (rst_n),
		.refresh (flush),
		.rs1     (s1_rs1),
		.rs2     (s1_rs2),
		.func    (s1_func),
		.cond    (cond)
	);

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (s1_valid) begin
			s2_kind   <= s1_kind;
			s2_target <= target_next;
			s2_link   <= s1_pc + data_bits'(4);  // return address
			s2_tag    <= s1_tag;
		end
	end

	// jumps are always taken
	assign take_branch  = (s2_kind == br_cond) ? cond : 1'b1;
	assign result_valid = s2_valid;
	assign result_tag   = s2_tag;
	assign target       = s2_target;
	assign link_value   = s2_link;

endmodule

/* sources.f */
logic/branch_pkg.sv
logic/branch_issue_if.sv
logic/branch_cond.sv
logic/branch_unit.sv
logic/branch_station.sv
logic/branch_top.sv
verification/branch_tb.sv

/* verification/branch_tb.sv */
`timescale 1ns/1ps

module branch_tb;
	import branch_pkg::*;

	logic         clock;
	logic         rst_n;
	logic         flush;
	logic         dispatch_valid;
	logic [31:0]  dispatch_pc;
	logic [31:0]  dispatch_inst;
	branch_kind_e dispatch_kind;
	logic         rs1_ready;
	logic [4:0]   rs1_tag;
	logic [31:0]  rs1_value;
	logic         rs2_ready;
	logic [4:0]   rs2_tag;
	logic [31:0]  rs2_value;
	logic [4:0]   dest_tag;
	logic         cdb_valid;
	logic [4:0]   cdb_tag;
	logic [31:0]  cdb_value;
	logic         dispatch_ready;
	logic         result_valid;
	logic [4:0]   result_tag;
	logic         take_branch;
	logic [31:0]  target;
	logic [31:0]  link_value;

	int cyc;  // rising edges since start

	// expected results in dispatch order
	string       name_q[$];
	logic [4:0]  tag_q[$];
	logic        taken_q[$];
	logic [31:0] target_q[$];
	logic [31:0] link_q[$];
	int          due_q[$];
	string       got_name;
	int          got_due;

	branch_top dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) cyc <= cyc + 1;

	task automatic report_error(input string msg);
		$display("Simulation failed");
		$fatal(1, "%s", msg);
	endtask

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Simulation failed");
			$fatal(1, "mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// {taken, target, link} from the RV32 branch rules
	function automatic logic [64:0] ref_branch(input branch_kind_e kind, input logic [31:0] pc,
			input logic [31:0] inst, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] imm;
		logic [31:0] tgt;
		logic        taken;
		taken = 1'b1;
		case (kind)
			br_jal: begin
				imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
				tgt = pc + imm;
			end
			br_jalr: begin
				imm = {{20{inst[31]}}, inst[31:20]};
				tgt = (a + imm) & 32'hffff_fffe;
			end
			default: begin
				imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
				tgt = pc + imm;
				case (br_func_e'(inst[14:12]))
					f_beq:   taken = (a == b);
					f_bne:   taken = (a != b);
					f_blt:   taken = ($signed(a) < $signed(b));
					f_bge:   taken = ($signed(a) >= $signed(b));
					f_bltu:  taken = (a < b);
					f_bgeu:  taken = (a >= b);
					default: taken = 1'b0;
				endcase
			end
		endcase
		return {taken, tgt, pc + 32'd4};
	endfunction

	// compare process, one pop per result strobe
	always @(negedge clock) begin
		if (rst_n && result_valid) begin
			if (name_q.size() == 0)
				report_error("result_valid appeared with no branch outstanding");
			got_name = name_q.pop_front();
			got_due  = due_q.pop_front();
			check({got_name, " tag"}, tag_q.pop_front(), result_tag);
			check({got_name, " taken"}, taken_q.pop_front(), take_branch);
			check({got_name, " target"}, target_q.pop_front(), target);
			check({got_name, " link"}, link_q.pop_front(), link_value);
			check({got_name, " cycle"}, got_due, cyc);
		end
	end

	task automatic wait_ready();
		int waited;
		waited = 0;
		@(negedge clock);
		while (!dispatch_ready) begin
			@(negedge clock);
			waited++;
			if (waited > 20) report_error("dispatch_ready stayed low for 20 cycles");
		end
	endtask

	// d1 and d2 are the wakeup cycles relative to dispatch, 0 is the dispatch cycle itself
	task automatic run_branch(input string name, input branch_kind_e kind, input logic [31:0] pc,
			input logic [31:0] inst, input logic [31:0] v1, input logic [31:0] v2,
			input logic rdy1, input logic rdy2, input int d1, input int d2, input bit expect_it);
		logic [4:0]  t1;
		logic [4:0]  t2;
		logic [4:0]  dt;
		logic [4:0]  nt;
		logic [64:0] exp;
		int          kmax;
		t1 = 5'($urandom);
		t2 = t1 ^ 5'($urandom_range(31, 1));
		dt = 5'($urandom);
		if (!rdy1 && !rdy2 && d1 == d2) d2 = d1 + 1;  // one broadcast per cycle
		kmax = 0;
		if (!rdy1 && d1 > kmax) kmax = d1;
		if (!rdy2 && d2 > kmax) kmax = d2;
		wait_ready();
		for (int k = 0; k <= kmax; k++) begin
			@(posedge clock);
			dispatch_valid <= (k == 0);
			if (k == 0) begin
				dispatch_pc   <= pc;
				dispatch_inst <= inst;
				dispatch_kind <= kind;
				rs1_ready     <= rdy1;
				rs1_tag       <= t1;
				rs1_value     <= rdy1 ? v1 : $urandom;
				rs2_ready     <= rdy2;
				rs2_tag       <= t2;
				rs2_value     <= rdy2 ? v2 : $urandom;
				dest_tag      <= dt;
			end
			if (!rdy1 && d1 == k) begin
				cdb_valid <= 1'b1;
				cdb_tag   <= t1;
				cdb_value <= v1;
			end else if (!rdy2 && d2 == k) begin
				cdb_valid <= 1'b1;
				cdb_tag   <= t2;
				cdb_value <= v2;
			end else begin
				nt = 5'($urandom);  // unrelated broadcast
				cdb_valid <= (nt != t1) && (nt != t2) && ($urandom_range(1, 0) == 1);
				cdb_tag   <= nt;
				cdb_value <= $urandom;
			end
		end
		@(posedge clock);
		dispatch_valid <= 1'b0;
		cdb_valid      <= 1'b0;
		@(negedge clock);
		if (expect_it) begin
			exp = ref_branch(kind, pc, inst, v1, v2);
			name_q.push_back(name);
			tag_q.push_back(dt);
			taken_q.push_back(exp[64]);
			target_q.push_back(exp[63:32]);
			link_q.push_back(exp[31:0]);
			due_q.push_back(cyc + 3);
		end
	endtask

	function automatic logic [31:0] cond_inst(input br_func_e f);
		logic [31:0] inst;
		inst = $urandom;
		inst[14:12] = f;
		inst[6:0]   = 7'b1100011;
		return inst;
	endfunction

	task automatic drain();
		int waited;
		waited = 0;
		while (name_q.size() != 0) begin
			@(negedge clock);
			waited++;
			if (waited > 20) report_error("no result within 20 cycles");
		end
	endtask

	initial begin
		logic [31:0] a_set[5];
		logic [31:0] b_set[5];
		br_func_e    funcs[6];
		branch_kind_e kind;
		logic [64:0] occ_exp;
		void'($urandom(96));
		cyc = 0;
		rst_n = 1'b0;
		flush = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_pc = '0;
		dispatch_inst = '0;
		dispatch_kind = br_cond;
		rs1_ready = 1'b0;
		rs1_tag = '0;
		rs1_value = '0;
		rs2_ready = 1'b0;
		rs2_tag = '0;
		rs2_value = '0;
		dest_tag = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_value = '0;
		repeat (10) @(posedge clock);
		rst_n <= 1'b1;

		// equal, sign bit and wrap boundaries
		a_set = '{32'h1234_5678, 32'h8000_0000, 32'h0000_0001, 32'hffff_ffff, $urandom};
		b_set = '{32'h1234_5678, 32'h0000_0001, 32'h8000_0000, 32'h0000_0000, $urandom};
		funcs = '{f_beq, f_bne, f_blt, f_bge, f_bltu, f_bgeu};
		foreach (funcs[i])
			foreach (a_set[j])
				run_branch($sformatf("cond %s pair %0d", funcs[i].name(), j), br_cond, $urandom,
					cond_inst(funcs[i]), a_set[j], b_set[j], 1, 1, 0, 0, 1);
		drain();

		run_branch("jal", br_jal, $urandom, $urandom, $urandom, $urandom, 1, 1, 0, 0, 1);
		run_branch("jalr odd", br_jalr, $urandom, 32'h0010_0067, 32'h0000_1000, 0, 1, 1, 0, 0, 1);
		run_branch("jalr", br_jalr, $urandom, $urandom, $urandom, $urandom, 1, 1, 0, 0, 1);
		drain();

		run_branch("wakeup late", br_cond, $urandom, cond_inst(f_blt), $urandom, $urandom,
			0, 0, 4, 6, 1);
		run_branch("wakeup at dispatch", br_cond, $urandom, cond_inst(f_bgeu), $urandom, $urandom,
			0, 1, 0, 0, 1);
		drain();

		// occupancy, entry waits on rs1 while a second dispatch is offered
		wait_ready();
		@(posedge clock);
		dispatch_valid <= 1'b1;
		dispatch_kind  <= br_jal;
		rs1_ready      <= 1'b0;
		rs1_tag        <= 5'd3;
		rs2_ready      <= 1'b1;
		dest_tag       <= 5'd9;
		@(posedge clock);
		dest_tag <= 5'd10;  // ignored while busy
		rs1_ready <= 1'b1;
		@(posedge clock);
		dispatch_valid <= 1'b0;
		@(negedge clock);
		check("occupancy ready low", 1'b0, dispatch_ready);
		@(posedge clock);
		cdb_valid <= 1'b1;
		cdb_tag   <= 5'd3;
		@(negedge clock);
		occ_exp = ref_branch(br_jal, dispatch_pc, dispatch_inst, 0, 0);
		name_q.push_back("occupancy");
		tag_q.push_back(5'd9);
		taken_q.push_back(1'b1);
		target_q.push_back(occ_exp[63:32]);
		link_q.push_back(dispatch_pc + 32'd4);
		due_q.push_back(cyc + 4);
		@(posedge clock);
		cdb_valid <= 1'b0;
		drain();
		wait_ready();

		// flush while waiting in the station, then while in the unit
		@(posedge clock);
		dispatch_valid <= 1'b1;
		rs1_ready      <= 1'b0;
		@(posedge clock);
		dispatch_valid <= 1'b0;
		flush          <= 1'b1;
		@(posedge clock);
		flush <= 1'b0;
		run_branch("flushed", br_jal, $urandom, $urandom, 0, 0, 1, 1, 0, 0, 0);
		@(posedge clock);
		@(posedge clock);
		flush <= 1'b1;
		@(posedge clock);
		flush <= 1'b0;
		repeat (10) @(negedge clock);
		run_branch("after flush", br_cond, $urandom, cond_inst(f_bne), 5, 6, 1, 1, 0, 0, 1);
		drain();

		for (int n = 0; n < 200; n++) begin
			kind = branch_kind_e'($urandom_range(2, 0));
			run_branch($sformatf("random %0d", n), kind, $urandom,
				cond_inst(funcs[$urandom_range(5, 0)]), $urandom, $urandom,
				$urandom_range(1, 0), $urandom_range(1, 0),
				$urandom_range(3, 0), $urandom_range(3, 0), 1);
		end
		drain();
		repeat (5) @(negedge clock);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
